// ==== immunity_core.f ====
+incdir+hw
hw/immunity_pkg.sv
hw/fetch_pc.sv
hw/pipe_reg.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/mem_access.sv
hw/immunity_core.sv
sim/immunity_props.sv
sim/immunity_tb.sv

// ==== sim/immunity_tb.sv ====
`timescale 1ns/1ps

module immunity_tb;

    localparam int OP_BEQ = 4;
    localparam int OP_BNE = 5;
    localparam int OP_ADDIU = 9;
    localparam int OP_ORI = 13;
    localparam int OP_LUI = 15;
    localparam int OP_LW = 35;
    localparam int OP_SW = 43;
    localparam int FN_SLL = 0;
    localparam int FN_SRL = 2;
    localparam int FN_ADDU = 33;
    localparam int FN_SUBU = 35;
    localparam int FN_AND = 36;
    localparam int FN_OR = 37;
    localparam int FN_XOR = 38;
    localparam int FN_SLT = 42;

    localparam int ROM_WORDS = 1024;
    localparam int RAM_WORDS = 256;
    localparam int STORE_TIMEOUT = 200;

    logic        clk;
    logic        rst_i;
    logic [31:0] rom_addr;
    logic        rom_en;
    logic [31:0] rom_inst;
    logic        ram_en;
    logic        ram_we;
    logic [3:0]  ram_sel;
    logic [31:0] ram_addr;
    logic [31:0] ram_wdata;
    logic [31:0] ram_rdata;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] ram [RAM_WORDS];

    // architectural view of the program as it is built
    logic [31:0] shadow [32];
    logic [31:0] sram [RAM_WORDS];
    logic        live;
    int          pc_w;
    int          next_addr;

    // expected stores, in program order
    logic [31:0] exp_addr [64];
    logic [31:0] exp_data [64];
    int          exp_count = 0;
    int          store_idx = 0;

    string       test_name = "none";
    int          fail_count = 0;
    int          errs_at_start;
    int          passed_tests = 0;
    int          failed_tests = 0;
    logic [31:0] lcg_state;

    immunity_core DUT (
        .clk             (clk),
        .rst_i           (rst_i),
        .rom_addr_o      (rom_addr),
        .rom_en_o        (rom_en),
        .rom_inst_i      (rom_inst),
        .ram_en_o        (ram_en),
        .ram_write_en_o  (ram_we),
        .ram_write_sel_o (ram_sel),
        .ram_addr_o      (ram_addr),
        .ram_write_data_o(ram_wdata),
        .ram_read_data_i (ram_rdata)
    );

    bind immunity_core immunity_props props0 (
        .clk             (clk),
        .rst_i           (rst_i),
        .rom_en_i        (rom_en_o),
        .rom_addr_i      (rom_addr_o),
        .stall_i         (stall),
        .branch_taken_i  (branch_taken),
        .ram_en_i        (ram_en_o),
        .ram_write_en_i  (ram_write_en_o),
        .ram_write_sel_i (ram_write_sel_o),
        .ram_addr_i      (ram_addr_o),
        .ram_write_data_i(ram_write_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] ram_fill(input int idx);
        return (32'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
    endfunction

    // asynchronous ROM and RAM reads
    assign rom_inst = rom[rom_addr[11:2]];
    assign ram_rdata = ram[ram_addr[9:2]];

    always @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                ram[i] <= ram_fill(i);
            end
        end else if (ram_en && ram_we) begin
            ram[ram_addr[9:2]] <= ram_wdata;
        end
    end

    always @(posedge clk) begin
        if (rst_i) begin
            store_idx <= 0;
        end else if (ram_we) begin
            store_idx <= store_idx + 1;
        end
    end

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
                                          input int sh, input int fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
    endfunction

    function automatic logic [31:0] enc_i(input int op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {6'(op), 5'(rs), 5'(rt), imm};
    endfunction

    task automatic put(input logic [31:0] inst);
        rom[pc_w] = inst;
        pc_w++;
    endtask

    task automatic emit_r(input int fn, input int rd, input int rs, input int rt, input int sh);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        a = shadow[rs];
        b = shadow[rt];
        case (fn)
            FN_ADDU: v = a + b;
            FN_SUBU: v = a - b;
            FN_AND:  v = a & b;
            FN_OR:   v = a | b;
            FN_XOR:  v = a ^ b;
            FN_SLT:  v = {31'b0, $signed(a) < $signed(b)};
            FN_SLL:  v = b << sh;
            default: v = b >> sh;
        endcase
        put(enc_r(rs, rt, rd, sh, fn));
        if (live && rd != 0) begin
            shadow[rd] = v;
        end
    endtask

    task automatic emit_i(input int op, input int rt, input int rs, input logic [15:0] imm);
        logic [31:0] sx;
        logic [31:0] addr;
        logic [31:0] v;
        sx = {{16{imm[15]}}, imm};
        addr = shadow[rs] + sx;
        v = shadow[rt];
        case (op)
            OP_ADDIU: v = shadow[rs] + sx;
            OP_ORI:   v = shadow[rs] | {16'h0000, imm};
            OP_LUI:   v = {imm, 16'h0000};
            OP_LW:    v = sram[addr[9:2]];
            default:  v = shadow[rt];
        endcase
        put(enc_i(op, rs, rt, imm));
        if (live && op == OP_SW) begin
            exp_addr[exp_count] = addr;
            exp_data[exp_count] = shadow[rt];
            exp_count++;
            sram[addr[9:2]] = shadow[rt];
        end else if (live && rt != 0) begin
            shadow[rt] = v;
        end
    endtask

    task automatic store_reg(input int rt);
        emit_i(OP_SW, rt, 0, 16'(next_addr));
        next_addr += 4;
    endtask

    task automatic load_const(input int rd, input logic [31:0] value);
        emit_i(OP_LUI, rd, 0, value[31:16]);
        emit_i(OP_ORI, rd, rd, value[15:0]);
    endtask

    // target is two words past the delay slot
    task automatic branch_case(input int op, input int rs, input int rt);
        logic taken;
        if (op == OP_BEQ) begin
            taken = shadow[rs] == shadow[rt];
        end else begin
            taken = shadow[rs] != shadow[rt];
        end
        put(enc_i(op, rs, rt, 16'd2));
        store_reg(rs);
        live = !taken;
        store_reg(rt);
        live = 1'b1;
        store_reg(3);
    endtask

    task automatic start_test(input string name);
        @(posedge clk);
        #1;
        rst_i = 1'b1;
        test_name = name;
        errs_at_start = fail_count;
        pc_w = 0;
        exp_count = 0;
        next_addr = 0;
        live = 1'b1;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            sram[i] = ram_fill(i);
        end
    endtask

    task automatic finish_test();
        int cycles;
        repeat (16) @(posedge clk);
        #1;
        rst_i = 1'b0;
        cycles = 0;
        while (store_idx < exp_count && cycles < STORE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        // let the tail of the program drain
        repeat (6) @(posedge clk);
        if (store_idx < exp_count) begin
            $display("test %s: timed out, saw %0d of %0d stores", test_name, store_idx,
                     exp_count);
            failed_tests++;
        end else if (fail_count != errs_at_start) begin
            $display("test %s: FAIL, %0d assertion errors", test_name,
                     fail_count - errs_at_start);
            failed_tests++;
        end else begin
            $display("test %s: pass, %0d stores", test_name, exp_count);
            passed_tests++;
        end
    endtask

    task automatic build_alu_chain();
        logic [31:0] r;
        for (int round = 0; round < 3; round++) begin
            load_const(1, rand_word());
            load_const(2, rand_word());
            emit_r(FN_ADDU, 3, 1, 2, 0);
            store_reg(3);
            emit_r(FN_SUBU, 4, 3, 1, 0);
            store_reg(4);
            emit_r(FN_AND, 5, 4, 3, 0);
            store_reg(5);
            emit_r(FN_OR, 6, 5, 2, 0);
            store_reg(6);
            emit_r(FN_XOR, 7, 6, 5, 0);
            store_reg(7);
            emit_r(FN_SLT, 8, 7, 1, 0);
            store_reg(8);
            r = rand_word();
            emit_r(FN_SLL, 9, 0, 7, int'(r[4:0]));
            store_reg(9);
            emit_r(FN_SRL, 10, 0, 9, int'(r[9:5]));
            store_reg(10);
            emit_i(OP_ADDIU, 11, 10, r[31:16]);
            store_reg(11);
            emit_i(OP_ORI, 12, 11, r[15:0]);
            store_reg(12);
            emit_i(OP_LUI, 13, 0, r[23:8]);
            store_reg(13);
        end
    endtask

    task automatic build_load_use();
        load_const(5, rand_word());
        emit_i(OP_SW, 5, 0, 16'h0200);
        emit_i(OP_LW, 6, 0, 16'h0200);
        // rs of the addu waits on the load
        emit_r(FN_ADDU, 7, 6, 5, 0);
        store_reg(7);
        emit_i(OP_LW, 8, 0, 16'h0300);
        store_reg(8);
        emit_i(OP_LW, 9, 0, 16'h0200);
        emit_r(FN_XOR, 10, 8, 9, 0);
        store_reg(10);
    endtask

    task automatic build_branches();
        load_const(1, rand_word());
        emit_r(FN_ADDU, 2, 1, 0, 0);
        emit_i(OP_ADDIU, 3, 1, 16'h0001);
        branch_case(OP_BEQ, 1, 2);
        branch_case(OP_BEQ, 1, 3);
        branch_case(OP_BNE, 1, 3);
        branch_case(OP_BNE, 1, 2);
    endtask

    initial begin
        rst_i = 1'b1;
        lcg_state = 32'd64369;
        start_test("alu_chain");
        build_alu_chain();
        finish_test();
        start_test("load_use");
        build_load_use();
        finish_test();
        start_test("branch_slot");
        build_branches();
        finish_test();
        $display("summary: %0d passed, %0d failed, %0d assertion errors", passed_tests,
                 failed_tests, fail_count);
        if (failed_tests == 0 && fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== sim/immunity_props.sv ====
`timescale 1ns/1ps

module immunity_props (
    input logic        clk,
    input logic        rst_i,
    input logic        rom_en_i,
    input logic [31:0] rom_addr_i,
    input logic        stall_i,
    input logic        branch_taken_i,
    input logic        ram_en_i,
    input logic        ram_write_en_i,
    input logic [3:0]  ram_write_sel_i,
    input logic [31:0] ram_addr_i,
    input logic [31:0] ram_write_data_i
);

    // no store beyond the expected table
    a_store_expected: assert property (@(posedge clk) disable iff (rst_i)
        ram_write_en_i |-> immunity_tb.store_idx < immunity_tb.exp_count)
    else begin
        immunity_tb.fail_count += 1;
        $error("unexpected store to %h in test %s", $sampled(ram_addr_i), immunity_tb.test_name);
    end

    // each store matches the head of the table
    a_store_value: assert property (@(posedge clk) disable iff (rst_i)
        ram_write_en_i && immunity_tb.store_idx < immunity_tb.exp_count |->
        ram_addr_i == immunity_tb.exp_addr[immunity_tb.store_idx] &&
        ram_write_data_i == immunity_tb.exp_data[immunity_tb.store_idx])
    else begin
        immunity_tb.fail_count += 1;
        $error("ERR %s store %0d expected %h at %h, actual %h at %h",
               immunity_tb.test_name, $sampled(immunity_tb.store_idx),
               immunity_tb.exp_data[$sampled(immunity_tb.store_idx)],
               immunity_tb.exp_addr[$sampled(immunity_tb.store_idx)],
               $sampled(ram_write_data_i), $sampled(ram_addr_i));
    end

    a_fetch_seq: assert property (@(posedge clk) disable iff (rst_i)
        !stall_i && !branch_taken_i |=> rom_addr_i == $past(rom_addr_i) + 32'd4)
    else begin
        immunity_tb.fail_count += 1;
        $error("ERR %s fetch expected %h, actual %h", immunity_tb.test_name,
               $past(rom_addr_i) + 32'd4, $sampled(rom_addr_i));
    end

    // first reset cycle may still show the old pipeline
    a_reset_quiet: assert property (@(posedge clk)
        rst_i && $past(rst_i) === 1'b1 |-> !rom_en_i && !ram_en_i && !ram_write_en_i)
    else begin
        immunity_tb.fail_count += 1;
        $error("fetch or data port active during reset in test %s", immunity_tb.test_name);
    end

    a_write_sel: assert property (@(posedge clk)
        ram_write_en_i |-> ram_en_i && ram_write_sel_i == 4'hf)
    else begin
        immunity_tb.fail_count += 1;
        $error("ERR %s byte select expected f, actual %h", immunity_tb.test_name,
               $sampled(ram_write_sel_i));
    end

endmodule

// ==== hw/immunity_core.sv ====
`timescale 1ns/1ps

`include "immunity_config.svh"

module immunity_core (
    input  logic                   clk,
    input  logic                   rst_i,

    output logic [`IMM_DATA_W-1:0] rom_addr_o,
    output logic                   rom_en_o,
    input  logic [`IMM_DATA_W-1:0] rom_inst_i,

    output logic                   ram_en_o,
    output logic                   ram_write_en_o,
    output logic [3:0]             ram_write_sel_o,
    output logic [`IMM_DATA_W-1:0] ram_addr_o,
    output logic [`IMM_DATA_W-1:0] ram_write_data_o,
    input  logic [`IMM_DATA_W-1:0] ram_read_data_i
);

    logic                   stall;
    logic                   branch_taken;
    logic [`IMM_DATA_W-1:0] branch_target;

    logic [`IMM_REG_AW-1:0] rs_addr;
    logic [`IMM_REG_AW-1:0] rt_addr;
    logic [`IMM_DATA_W-1:0] rs_data;
    logic [`IMM_DATA_W-1:0] rt_data;

    immunity_pkg::if_id_t   if_d;
    immunity_pkg::if_id_t   id_q;
    immunity_pkg::id_ex_t   id_d;
    immunity_pkg::id_ex_t   ex_q;
    immunity_pkg::ex_mem_t  ex_d;
    immunity_pkg::ex_mem_t  mem_q;
    immunity_pkg::mem_wb_t  mem_d;
    immunity_pkg::mem_wb_t  wb_q;

    assign if_d.addr = rom_addr_o;
    assign if_d.inst = rom_inst_i;

    fetch_pc pc0 (
        .clk            (clk),
        .rst_i          (rst_i),
        .stall_i        (stall),
        .branch_taken_i (branch_taken),
        .branch_target_i(branch_target),
        .rom_en_o       (rom_en_o),
        .pc_o           (rom_addr_o)
    );

    // IF/ID freezes on a load-use stall
    pipe_reg #(.payload_t(immunity_pkg::if_id_t)) if_id_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .hold_i  (stall),
        .bubble_i(1'b0),
        .d_i     (if_d),
        .q_o     (id_q)
    );

    decode_stage id0 (
        .id_i           (id_q),
        .rs_addr_o      (rs_addr),
        .rt_addr_o      (rt_addr),
        .rs_data_i      (rs_data),
        .rt_data_i      (rt_data),
        .ex_fwd_i       (ex_d),
        .mem_fwd_i      (mem_d),
        .id_ex_o        (id_d),
        .branch_taken_o (branch_taken),
        .branch_target_o(branch_target),
        .stall_o        (stall)
    );

    reg_file regfile0 (
        .clk      (clk),
        .rst_i    (rst_i),
        .rs_addr_i(rs_addr),
        .rt_addr_i(rt_addr),
        .rs_data_o(rs_data),
        .rt_data_o(rt_data),
        .wb_i     (wb_q)
    );

    // bubble into EX while ID waits on the load
    pipe_reg #(.payload_t(immunity_pkg::id_ex_t)) id_ex_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .hold_i  (1'b0),
        .bubble_i(stall),
        .d_i     (id_d),
        .q_o     (ex_q)
    );

    execute_stage ex0 (
        .id_ex_i (ex_q),
        .ex_mem_o(ex_d)
    );

    pipe_reg #(.payload_t(immunity_pkg::ex_mem_t)) ex_mem_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .hold_i  (1'b0),
        .bubble_i(1'b0),
        .d_i     (ex_d),
        .q_o     (mem_q)
    );

    mem_access mem0 (
        .ex_mem_i        (mem_q),
        .ram_en_o        (ram_en_o),
        .ram_write_en_o  (ram_write_en_o),
        .ram_write_sel_o (ram_write_sel_o),
        .ram_addr_o      (ram_addr_o),
        .ram_write_data_o(ram_write_data_o),
        .ram_read_data_i (ram_read_data_i),
        .mem_wb_o        (mem_d)
    );

    pipe_reg #(.payload_t(immunity_pkg::mem_wb_t)) mem_wb_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .hold_i  (1'b0),
        .bubble_i(1'b0),
        .d_i     (mem_d),
        .q_o     (wb_q)
    );

endmodule

// ==== hw/mem_access.sv ====
`timescale 1ns/1ps

`include "immunity_config.svh"

module mem_access (
    input  immunity_pkg::ex_mem_t  ex_mem_i,
    output logic                   ram_en_o,
    output logic                   ram_write_en_o,
    output logic [3:0]             ram_write_sel_o,
    output logic [`IMM_DATA_W-1:0] ram_addr_o,
    output logic [`IMM_DATA_W-1:0] ram_write_data_o,
    input  logic [`IMM_DATA_W-1:0] ram_read_data_i,
    output immunity_pkg::mem_wb_t  mem_wb_o
);

    // word accesses only, all byte lanes on a store
    assign ram_en_o         = ex_mem_i.load | ex_mem_i.store;
    assign ram_write_en_o   = ex_mem_i.store;
    assign ram_write_sel_o  = {4{ex_mem_i.store}};
    assign ram_addr_o       = ex_mem_i.result;
    assign ram_write_data_o = ex_mem_i.store_data;

    always_comb begin
        mem_wb_o.reg_write_en   = ex_mem_i.reg_write_en;
        mem_wb_o.reg_write_addr = ex_mem_i.reg_write_addr;
        if (ex_mem_i.load) begin
            mem_wb_o.write_data = ram_read_data_i;
        end else begin
            mem_wb_o.write_data = ex_mem_i.result;
        end
    end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps

`include "immunity_config.svh"

module execute_stage (
    input  immunity_pkg::id_ex_t  id_ex_i,
    output immunity_pkg::ex_mem_t ex_mem_o
);

    logic [`IMM_DATA_W-1:0] op_a;
    logic [`IMM_DATA_W-1:0] op_b;
    logic [`IMM_DATA_W-1:0] result;
    logic                   less;

    assign op_a = id_ex_i.operand_1;
    assign op_b = id_ex_i.operand_2;
    assign less = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (id_ex_i.alu_op)
            immunity_pkg::ALU_ADD: result = op_a + op_b;
            immunity_pkg::ALU_SUB: result = op_a - op_b;
            immunity_pkg::ALU_AND: result = op_a & op_b;
            immunity_pkg::ALU_OR:  result = op_a | op_b;
            immunity_pkg::ALU_XOR: result = op_a ^ op_b;
            immunity_pkg::ALU_SLT: result = {{(`IMM_DATA_W-1){1'b0}}, less};
            // shifts act on rt, carried in operand 2
            immunity_pkg::ALU_SLL: result = op_b << id_ex_i.shamt;
            immunity_pkg::ALU_SRL: result = op_b >> id_ex_i.shamt;
            immunity_pkg::ALU_LUI: result = {op_b[15:0], 16'h0000};
            default:               result = '0;
        endcase
    end

    always_comb begin
        ex_mem_o.result         = result;
        ex_mem_o.store_data     = id_ex_i.store_data;
        ex_mem_o.reg_write_en   = id_ex_i.reg_write_en;
        ex_mem_o.reg_write_addr = id_ex_i.reg_write_addr;
        ex_mem_o.load           = id_ex_i.load;
        ex_mem_o.store          = id_ex_i.store;
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

`include "immunity_config.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [`IMM_REG_AW-1:0] rs_addr_i,
    input  logic [`IMM_REG_AW-1:0] rt_addr_i,
    output logic [`IMM_DATA_W-1:0] rs_data_o,
    output logic [`IMM_DATA_W-1:0] rt_data_o,
    input  immunity_pkg::mem_wb_t  wb_i
);

    logic [`IMM_DATA_W-1:0] regs [`IMM_REG_N];
    logic                   wr_live;

    assign wr_live = wb_i.reg_write_en && wb_i.reg_write_addr != '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `IMM_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wb_i.reg_write_addr] <= wb_i.write_data;
        end
    end

    // write-through so WB and ID can share a cycle
    function automatic logic [`IMM_DATA_W-1:0] read_port(input logic [`IMM_REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_live && wb_i.reg_write_addr == addr) begin
            return wb_i.write_data;
        end
        return regs[addr];
    endfunction

    assign rs_data_o = read_port(rs_addr_i);
    assign rt_data_o = read_port(rt_addr_i);

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps

`include "immunity_config.svh"

module decode_stage (
    input  immunity_pkg::if_id_t   id_i,
    output logic [`IMM_REG_AW-1:0] rs_addr_o,
    output logic [`IMM_REG_AW-1:0] rt_addr_o,
    input  logic [`IMM_DATA_W-1:0] rs_data_i,
    input  logic [`IMM_DATA_W-1:0] rt_data_i,
    input  immunity_pkg::ex_mem_t  ex_fwd_i,
    input  immunity_pkg::mem_wb_t  mem_fwd_i,
    output immunity_pkg::id_ex_t   id_ex_o,
    output logic                   branch_taken_o,
    output logic [`IMM_DATA_W-1:0] branch_target_o,
    output logic                   stall_o
);

    logic [5:0]             opcode;
    logic [5:0]             funct;
    logic [`IMM_REG_AW-1:0] rd_addr;
    logic [4:0]             shamt;
    logic [`IMM_DATA_W-1:0] imm_sext;
    logic [`IMM_DATA_W-1:0] imm_zext;
    logic [`IMM_DATA_W-1:0] rs_val;
    logic [`IMM_DATA_W-1:0] rt_val;
    logic                   uses_rs;
    logic                   uses_rt;

    assign opcode    = id_i.inst[31:26];
    assign rs_addr_o = id_i.inst[25:21];
    assign rt_addr_o = id_i.inst[20:16];
    assign rd_addr   = id_i.inst[15:11];
    assign shamt     = id_i.inst[10:6];
    assign funct     = id_i.inst[5:0];
    assign imm_sext  = {{(`IMM_DATA_W-16){id_i.inst[15]}}, id_i.inst[15:0]};
    assign imm_zext  = {{(`IMM_DATA_W-16){1'b0}}, id_i.inst[15:0]};

    // newest producer wins, r0 is never bypassed
    function automatic logic [`IMM_DATA_W-1:0] bypass(
        input logic [`IMM_REG_AW-1:0] addr,
        input logic [`IMM_DATA_W-1:0] rf_data
    );
        if (addr != '0 && ex_fwd_i.reg_write_en && ex_fwd_i.reg_write_addr == addr) begin
            return ex_fwd_i.result;
        end
        if (addr != '0 && mem_fwd_i.reg_write_en && mem_fwd_i.reg_write_addr == addr) begin
            return mem_fwd_i.write_data;
        end
        return rf_data;
    endfunction

    assign rs_val = bypass(rs_addr_o, rs_data_i);
    assign rt_val = bypass(rt_addr_o, rt_data_i);

    assign branch_target_o = id_i.addr + `IMM_DATA_W'(4) + {imm_sext[`IMM_DATA_W-3:0], 2'b00};

    always_comb begin
        id_ex_o                = '0;
        id_ex_o.alu_op         = immunity_pkg::ALU_ADD;
        id_ex_o.operand_1      = rs_val;
        id_ex_o.operand_2      = rt_val;
        id_ex_o.store_data     = rt_val;
        id_ex_o.reg_write_addr = rt_addr_o;
        uses_rs                = 1'b0;
        uses_rt                = 1'b0;
        branch_taken_o         = 1'b0;

        case (opcode)
            immunity_pkg::OP_SPECIAL: begin
                id_ex_o.reg_write_addr = rd_addr;
                id_ex_o.reg_write_en   = 1'b1;
                uses_rs                = 1'b1;
                uses_rt                = 1'b1;
                case (funct)
                    immunity_pkg::F_ADDU: id_ex_o.alu_op = immunity_pkg::ALU_ADD;
                    immunity_pkg::F_SUBU: id_ex_o.alu_op = immunity_pkg::ALU_SUB;
                    immunity_pkg::F_AND:  id_ex_o.alu_op = immunity_pkg::ALU_AND;
                    immunity_pkg::F_OR:   id_ex_o.alu_op = immunity_pkg::ALU_OR;
                    immunity_pkg::F_XOR:  id_ex_o.alu_op = immunity_pkg::ALU_XOR;
                    immunity_pkg::F_SLT:  id_ex_o.alu_op = immunity_pkg::ALU_SLT;
                    immunity_pkg::F_SLL, immunity_pkg::F_SRL: begin
                        // shifts take rt only
                        id_ex_o.alu_op = (funct == immunity_pkg::F_SLL) ?
                                         immunity_pkg::ALU_SLL : immunity_pkg::ALU_SRL;
                        id_ex_o.shamt  = shamt;
                        uses_rs        = 1'b0;
                    end
                    default: id_ex_o.reg_write_en = 1'b0;
                endcase
            end
            immunity_pkg::OP_ADDIU, immunity_pkg::OP_LW: begin
                id_ex_o.operand_2    = imm_sext;
                id_ex_o.reg_write_en = 1'b1;
                id_ex_o.load         = (opcode == immunity_pkg::OP_LW);
                uses_rs              = 1'b1;
            end
            immunity_pkg::OP_ORI: begin
                id_ex_o.alu_op       = immunity_pkg::ALU_OR;
                id_ex_o.operand_2    = imm_zext;
                id_ex_o.reg_write_en = 1'b1;
                uses_rs              = 1'b1;
            end
            immunity_pkg::OP_LUI: begin
                id_ex_o.alu_op       = immunity_pkg::ALU_LUI;
                id_ex_o.operand_2    = imm_zext;
                id_ex_o.reg_write_en = 1'b1;
            end
            immunity_pkg::OP_SW: begin
                id_ex_o.operand_2 = imm_sext;
                id_ex_o.store     = 1'b1;
                uses_rs           = 1'b1;
                uses_rt           = 1'b1;
            end
            immunity_pkg::OP_BEQ, immunity_pkg::OP_BNE: begin
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                branch_taken_o = (rs_val == rt_val) ^ (opcode == immunity_pkg::OP_BNE);
            end
            default: ;
        endcase
    end

    // load in EX has no data yet, hold ID for one cycle
    assign stall_o = ex_fwd_i.load && ex_fwd_i.reg_write_addr != '0 &&
                     ((uses_rs && ex_fwd_i.reg_write_addr == rs_addr_o) ||
                      (uses_rt && ex_fwd_i.reg_write_addr == rt_addr_o));

endmodule

// ==== hw/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     hold_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // all-zero payload has every enable low
    always_ff @(posedge clk) begin
        if (rst_i || bubble_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

// ==== hw/fetch_pc.sv ====
`timescale 1ns/1ps

`include "immunity_config.svh"

module fetch_pc (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   stall_i,
    input  logic                   branch_taken_i,
    input  logic [`IMM_DATA_W-1:0] branch_target_i,
    output logic                   rom_en_o,
    output logic [`IMM_DATA_W-1:0] pc_o
);

    // fetch is live as soon as reset is released
    assign rom_en_o = ~rst_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_o <= `IMM_RESET_PC;
        end else if (!stall_i) begin
            // a taken branch in ID lands after its delay slot
            if (branch_taken_i) begin
                pc_o <= branch_target_i;
            end else begin
                pc_o <= pc_o + `IMM_DATA_W'(4);
            end
        end
    end

endmodule

// ==== hw/immunity_pkg.sv ====
`include "immunity_config.svh"

package immunity_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } funct_e;

    // add must stay at zero so a bubble decodes as a harmless add
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [`IMM_DATA_W-1:0] addr;
        logic [`IMM_DATA_W-1:0] inst;
    } if_id_t;

    typedef struct packed {
        alu_op_e                alu_op;
        logic [`IMM_DATA_W-1:0] operand_1;
        logic [`IMM_DATA_W-1:0] operand_2;
        logic [4:0]             shamt;
        logic [`IMM_DATA_W-1:0] store_data;
        logic                   reg_write_en;
        logic [`IMM_REG_AW-1:0] reg_write_addr;
        logic                   load;
        logic                   store;
    } id_ex_t;

    typedef struct packed {
        logic [`IMM_DATA_W-1:0] result;
        logic [`IMM_DATA_W-1:0] store_data;
        logic                   reg_write_en;
        logic [`IMM_REG_AW-1:0] reg_write_addr;
        logic                   load;
        logic                   store;
    } ex_mem_t;

    typedef struct packed {
        logic [`IMM_DATA_W-1:0] write_data;
        logic                   reg_write_en;
        logic [`IMM_REG_AW-1:0] reg_write_addr;
    } mem_wb_t;

endpackage

// ==== hw/immunity_config.svh ====
`ifndef IMMUNITY_CONFIG_SVH
`define IMMUNITY_CONFIG_SVH

// data path and address width
`define IMM_DATA_W 32

// register file geometry
`define IMM_REG_AW 5
`define IMM_REG_N 32

// first fetch address out of reset
`define IMM_RESET_PC 32'h0000_0000

`endif
